//--- verilog/vlsu_axi_macros.svh
// Bus widths and burst size limits for the VLSU AXI4 master
// Shared by the package and the RTL blocks

`ifndef VLSU_AXI_MACROS_SVH
`define VLSU_AXI_MACROS_SVH

// ====================
// Bus widths
// ====================
`define VLSU_DATA_W     32
`define VLSU_ADDR_W     32

// Byte lanes per beat
`define VLSU_STRB_W     (`VLSU_DATA_W / 8)

// ====================
// Burst shape
// ====================
`define VLSU_BURST_MAX  4
`define VLSU_LEN_W      8
`define VLSU_ID_W       4

`endif

//--- verilog/vlsu_axi_pkg.sv
// Width typedefs, AXI response codes and controller states
// for the VLSU AXI4 burst master

`default_nettype none

`include "vlsu_axi_macros.svh"

package vlsu_axi_pkg;

    // Single beat and address
    typedef logic [`VLSU_ADDR_W-1:0]                 addr_t;
    typedef logic [`VLSU_DATA_W-1:0]                 data_t;
    typedef logic [`VLSU_STRB_W-1:0]                 strb_t;

    // Whole burst, beat i at bit i*DATA_W
    typedef logic [`VLSU_DATA_W*`VLSU_BURST_MAX-1:0] burst_data_t;
    typedef logic [`VLSU_STRB_W*`VLSU_BURST_MAX-1:0] burst_strb_t;

    // axlen carries beats minus one
    typedef logic [`VLSU_LEN_W-1:0]                  len_t;
    typedef logic [`VLSU_ID_W-1:0]                   id_t;
    typedef logic [1:0]                              resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Channel controller phases
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_WR_ADDR,
        ST_WR_DATA,
        ST_WR_RESP
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/burst_config_regs.sv
// Saved burst configuration for first issue and retries
// Transaction ID generator, one step per accepted request

`timescale 1ns/1ps
`default_nettype none

module burst_config_regs
    import vlsu_axi_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Request accept strobe from the channel controller
    input  logic        req_accept,

    // Unit side request fields, valid with the strobe
    input  addr_t       base_addr,
    input  len_t        burst_len,
    input  burst_data_t vlsu_wdata,
    input  burst_strb_t write_strobe,

    // Saved configuration
    output addr_t       cfg_addr,
    output len_t        cfg_len,
    output burst_data_t cfg_wdata,
    output burst_strb_t cfg_wstrb,
    output id_t         cur_id
);

    // ID that the next accepted request will take
    id_t next_id;

    // ====================
    // Request capture
    // ====================

    // Held for the whole burst, retries reuse the same values
    always_ff @(posedge clk) begin
        if (req_accept) begin
            cfg_addr  <= base_addr;
            cfg_len   <= burst_len;
            cfg_wdata <= vlsu_wdata;
            cfg_wstrb <= write_strobe;
        end
    end

    // ====================
    // ID generator
    // ====================

    // First burst after reset gets ID 0
    // Wraps modulo 16, retries never advance it
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            next_id <= '0;
            cur_id  <= '0;
        end else if (req_accept) begin
            cur_id  <= next_id;
            next_id <= next_id + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/axi_channel_ctrl.sv
// FSM driving the AXI4 channel valid/ready signals
// Write beat sequencing with wlast generation

`timescale 1ns/1ps
`default_nettype none

`include "vlsu_axi_macros.svh"

module axi_channel_ctrl
    import vlsu_axi_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Unit side request strobes
    input  logic        ld_req,
    input  logic        st_req,

    // Slave side handshakes
    input  logic        s_arready,
    input  logic        s_awready,
    input  logic        s_wready,
    input  logic        s_rvalid,
    input  logic        s_bvalid,

    // Completion decisions
    input  logic        rd_done,
    input  logic        rd_retry,
    input  logic        wr_done,
    input  logic        wr_retry,

    // Saved burst configuration
    input  len_t        cfg_len,
    input  burst_data_t cfg_wdata,
    input  burst_strb_t cfg_wstrb,

    // AXI channel control
    output logic        m_arvalid,
    output logic        m_awvalid,
    output logic        m_wvalid,
    output logic        m_wlast,
    output logic        m_rready,
    output logic        m_bready,
    output logic        busy,

    // Internal strobes
    output logic        req_accept,
    output logic        req_is_load,
    output logic        rd_start,
    output logic        wr_start,

    // Current write beat
    output data_t       m_wdata,
    output strb_t       m_wstrb
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // Index of the write beat on the bus
    len_t beat_cnt;

    // ====================
    // Request and channel decode
    // ====================

    // Requests only count in idle, load wins over store
    assign req_accept  = (state == ST_IDLE) && (ld_req || st_req);
    assign req_is_load = (state == ST_IDLE) && ld_req;

    assign m_arvalid = (state == ST_RD_ADDR);
    assign m_awvalid = (state == ST_WR_ADDR);
    assign m_rready  = (state == ST_RD_DATA);
    assign m_wvalid  = (state == ST_WR_DATA);
    assign m_bready  = (state == ST_WR_RESP);
    assign busy      = (state != ST_IDLE);

    // Address handshakes open the completion tracking
    assign rd_start = m_arvalid && s_arready;
    assign wr_start = m_awvalid && s_awready;

    // ====================
    // Phase FSM
    // ====================

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req_is_load)
                    state_next = ST_RD_ADDR;
                else if (req_accept)
                    state_next = ST_WR_ADDR;
            end
            ST_RD_ADDR: begin
                if (s_arready)
                    state_next = ST_RD_DATA;
            end
            // Stays here through stray-ID beats
            ST_RD_DATA: begin
                if (rd_retry)
                    state_next = ST_RD_ADDR;
                else if (rd_done)
                    state_next = ST_IDLE;
            end
            ST_WR_ADDR: begin
                if (s_awready)
                    state_next = ST_WR_DATA;
            end
            ST_WR_DATA: begin
                if (s_wready && m_wlast)
                    state_next = ST_WR_RESP;
            end
            ST_WR_RESP: begin
                if (wr_retry)
                    state_next = ST_WR_ADDR;
                else if (wr_done)
                    state_next = ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    // ====================
    // Write beat sequencing
    // ====================

    // Restarts at beat 0 on every aw handshake, retries included
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            beat_cnt <= '0;
        else if (wr_start)
            beat_cnt <= '0;
        else if (m_wvalid && s_wready && !m_wlast)
            beat_cnt <= beat_cnt + 1'b1;
    end

    // Full-width beats, slice picked by the beat index
    assign m_wdata = cfg_wdata[beat_cnt[1:0]*`VLSU_DATA_W +: `VLSU_DATA_W];
    assign m_wstrb = cfg_wstrb[beat_cnt[1:0]*`VLSU_STRB_W +: `VLSU_STRB_W];
    assign m_wlast = m_wvalid && (beat_cnt == cfg_len);

    // ====================
    // Protocol checks
    // ====================

    // Shared address bus carries one channel at a time
    a_addr_excl: assert property (@(posedge clk) disable iff (!reset)
        !(m_arvalid && m_awvalid));

    a_ar_hold: assert property (@(posedge clk) disable iff (!reset)
        m_arvalid && !s_arready |=> m_arvalid);

    a_aw_hold: assert property (@(posedge clk) disable iff (!reset)
        m_awvalid && !s_awready |=> m_awvalid);

endmodule

`default_nettype wire

//--- verilog/burst_completion.sv
// Read beat assembly into the wide burst word
// Read and write response checks with done/retry decision

`timescale 1ns/1ps
`default_nettype none

`include "vlsu_axi_macros.svh"

module burst_completion
    import vlsu_axi_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Strobes from the channel controller
    input  logic        rd_start,
    input  logic        wr_start,
    input  logic        req_accept,

    // Read data channel
    input  logic        s_rvalid,
    input  logic        m_rready,
    input  logic        s_rlast,
    input  data_t       s_rdata,
    input  id_t         s_rid,
    input  resp_t       s_rresp,

    // Write response channel
    input  logic        s_bvalid,
    input  logic        m_bready,
    input  id_t         s_bid,
    input  resp_t       s_bresp,

    // ID of the burst in flight
    input  id_t         cur_id,

    // Unit side results
    output burst_data_t burst_rdata_array,
    output logic        burst_valid_data,
    output logic        burst_wr_valid,

    // Decisions back to the controller
    output logic        rd_done,
    output logic        rd_retry,
    output logic        wr_done,
    output logic        wr_retry
);

    // Beat slot for the next matching read beat
    logic [2:0] beat_idx;
    logic       rd_err;
    logic       wr_wait;

    logic       rd_match;
    logic       rd_last_hit;
    logic       rd_err_now;
    logic       wr_hit;

    // ====================
    // Read side
    // ====================

    // Foreign IDs are accepted but ignored
    assign rd_match    = s_rvalid && m_rready && (s_rid == cur_id);
    assign rd_last_hit = rd_match && s_rlast;

    // Error on the last beat itself counts too
    assign rd_err_now  = rd_err || (s_rresp != RESP_OKAY);
    assign rd_done     = rd_last_hit && !rd_err_now;
    assign rd_retry    = rd_last_hit && rd_err_now;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            beat_idx <= '0;
            rd_err   <= 1'b0;
        end else if (rd_start) begin
            beat_idx <= '0;
            rd_err   <= 1'b0;
        end else if (rd_match) begin
            beat_idx <= beat_idx + 1'b1;
            if (s_rresp != RESP_OKAY)
                rd_err <= 1'b1;
        end
    end

    // Every matching beat lands in its slot, a retry rewrites them all
    always_ff @(posedge clk) begin
        if (rd_match)
            burst_rdata_array[beat_idx[1:0]*`VLSU_DATA_W +: `VLSU_DATA_W] <= s_rdata;
    end

    // ====================
    // Write side
    // ====================

    // Pending from aw handshake to the matching response
    assign wr_hit   = s_bvalid && m_bready && wr_wait && (s_bid == cur_id);
    assign wr_done  = wr_hit && (s_bresp == RESP_OKAY);
    assign wr_retry = wr_hit && (s_bresp != RESP_OKAY);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            wr_wait <= 1'b0;
        else if (wr_start)
            wr_wait <= 1'b1;
        else if (wr_hit)
            wr_wait <= 1'b0;
    end

    // ====================
    // Done flags
    // ====================

    // Levels, dropped when the next request is taken
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            burst_valid_data <= 1'b0;
            burst_wr_valid   <= 1'b0;
        end else if (req_accept) begin
            burst_valid_data <= 1'b0;
            burst_wr_valid   <= 1'b0;
        end else begin
            if (rd_done)
                burst_valid_data <= 1'b1;
            if (wr_done)
                burst_wr_valid <= 1'b1;
        end
    end

    // At most one completion decision per cycle across both directions
    a_one_decision: assert property (@(posedge clk) disable iff (!reset)
        $onehot0({rd_done, rd_retry, wr_done, wr_retry}));

    // Slave never sends more matching beats than a burst can hold
    a_beat_bound: assert property (@(posedge clk) disable iff (!reset)
        rd_match |-> (beat_idx < `VLSU_BURST_MAX));

endmodule

`default_nettype wire

//--- verilog/vlsu_axi_master.sv
// VLSU AXI4 burst master top level
// Config registers, channel controller and completion logic

`timescale 1ns/1ps
`default_nettype none

module vlsu_axi_master
    import vlsu_axi_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // ====================
    // Unit side
    // ====================
    input  logic        ld_req,
    input  logic        st_req,
    input  addr_t       base_addr,
    input  len_t        burst_len,
    input  burst_data_t vlsu_wdata,
    input  burst_strb_t write_strobe,
    output burst_data_t burst_rdata_array,
    output logic        burst_valid_data,
    output logic        burst_wr_valid,
    output logic        busy,

    // ====================
    // AXI side
    // ====================

    // Shared address bus for ar and aw
    output addr_t       m_axaddr,
    output len_t        m_axlen,
    output id_t         m_axid,
    output logic        m_arvalid,
    output logic        m_awvalid,
    input  logic        s_arready,
    input  logic        s_awready,

    // Write data
    output data_t       m_wdata,
    output strb_t       m_wstrb,
    output logic        m_wlast,
    output logic        m_wvalid,
    input  logic        s_wready,

    // Read data
    input  logic        s_rvalid,
    input  data_t       s_rdata,
    input  id_t         s_rid,
    input  resp_t       s_rresp,
    input  logic        s_rlast,
    output logic        m_rready,

    // Write response
    input  logic        s_bvalid,
    input  id_t         s_bid,
    input  resp_t       s_bresp,
    output logic        m_bready
);

    burst_data_t cfg_wdata;
    burst_strb_t cfg_wstrb;

    logic req_accept;
    logic rd_start;
    logic wr_start;
    logic rd_done;
    logic rd_retry;
    logic wr_done;
    logic wr_retry;

    // Saved address, length and ID go straight onto the address bus
    burst_config_regs config_i (
        .clk          (clk),
        .reset        (reset),
        .req_accept   (req_accept),
        .base_addr    (base_addr),
        .burst_len    (burst_len),
        .vlsu_wdata   (vlsu_wdata),
        .write_strobe (write_strobe),
        .cfg_addr     (m_axaddr),
        .cfg_len      (m_axlen),
        .cfg_wdata    (cfg_wdata),
        .cfg_wstrb    (cfg_wstrb),
        .cur_id       (m_axid)
    );

    // Load/store select only steers the controller's own phase choice
    axi_channel_ctrl ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .ld_req      (ld_req),
        .st_req      (st_req),
        .s_arready   (s_arready),
        .s_awready   (s_awready),
        .s_wready    (s_wready),
        .s_rvalid    (s_rvalid),
        .s_bvalid    (s_bvalid),
        .rd_done     (rd_done),
        .rd_retry    (rd_retry),
        .wr_done     (wr_done),
        .wr_retry    (wr_retry),
        .cfg_len     (m_axlen),
        .cfg_wdata   (cfg_wdata),
        .cfg_wstrb   (cfg_wstrb),
        .m_arvalid   (m_arvalid),
        .m_awvalid   (m_awvalid),
        .m_wvalid    (m_wvalid),
        .m_wlast     (m_wlast),
        .m_rready    (m_rready),
        .m_bready    (m_bready),
        .busy        (busy),
        .req_accept  (req_accept),
        .req_is_load (),
        .rd_start    (rd_start),
        .wr_start    (wr_start),
        .m_wdata     (m_wdata),
        .m_wstrb     (m_wstrb)
    );

    burst_completion completion_i (
        .clk               (clk),
        .reset             (reset),
        .rd_start          (rd_start),
        .wr_start          (wr_start),
        .req_accept        (req_accept),
        .s_rvalid          (s_rvalid),
        .m_rready          (m_rready),
        .s_rlast           (s_rlast),
        .s_rdata           (s_rdata),
        .s_rid             (s_rid),
        .s_rresp           (s_rresp),
        .s_bvalid          (s_bvalid),
        .m_bready          (m_bready),
        .s_bid             (s_bid),
        .s_bresp           (s_bresp),
        .cur_id            (m_axid),
        .burst_rdata_array (burst_rdata_array),
        .burst_valid_data  (burst_valid_data),
        .burst_wr_valid    (burst_wr_valid),
        .rd_done           (rd_done),
        .rd_retry          (rd_retry),
        .wr_done           (wr_done),
        .wr_retry          (wr_retry)
    );

endmodule

`default_nettype wire

//--- tests/axi_mem_model.sv
// Behavioral AXI4 slave with a byte memory and random ready delays
// Error injection on first attempts, stray-ID read beats, address log

`timescale 1ns/1ps
`default_nettype none

module axi_mem_model
    import vlsu_axi_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Test controls, held for a whole request
    input  logic  inject_err,
    input  logic  stray_en,

    // Shared address bus
    input  addr_t m_axaddr,
    input  len_t  m_axlen,
    input  id_t   m_axid,
    input  logic  m_arvalid,
    input  logic  m_awvalid,
    output logic  s_arready,
    output logic  s_awready,

    // Write data
    input  data_t m_wdata,
    input  strb_t m_wstrb,
    input  logic  m_wlast,
    input  logic  m_wvalid,
    output logic  s_wready,

    // Read data
    output logic  s_rvalid,
    output data_t s_rdata,
    output id_t   s_rid,
    output resp_t s_rresp,
    output logic  s_rlast,
    input  logic  m_rready,

    // Write response
    output logic  s_bvalid,
    output id_t   s_bid,
    output resp_t s_bresp,
    input  logic  m_bready
);

    // 1 KiB byte memory, filled by the testbench
    logic [7:0] mem [0:1023];

    // Address handshake log
    addr_t log_addr [0:255];
    len_t  log_len  [0:255];
    id_t   log_id   [0:255];
    logic  log_rd   [0:255];
    int    log_cnt;

    // Protocol problems seen on the master side
    int    wlast_err;
    int    stall_cnt;

    logic [31:0] rng;

    // Burst in service and the previous one, for retry detection
    addr_t cur_addr;
    len_t  cur_len;
    id_t   cur_id;
    logic  first_try;
    addr_t prev_addr;
    id_t   prev_id;
    logic  prev_rd;
    logic  prev_ok;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Little endian, byte lane k at address a+k
    function automatic data_t read_word(input addr_t a);
        return {mem[a[9:0] + 10'd3], mem[a[9:0] + 10'd2], mem[a[9:0] + 10'd1], mem[a[9:0]]};
    endfunction

    // One clock, outputs change 1 ns after the edge
    task automatic cycle;
        @(posedge clk);
        #1;
    endtask

    // Channel 0 is r, 1 is w, 2 is b
    task automatic wait_ready(input int ch);
        int n;
        logic rdy;
        n = 0;
        @(negedge clk);
        rdy = (ch == 0) ? m_rready : (ch == 1) ? m_wvalid : m_bready;
        while (!rdy && n < 1000) begin
            n++;
            @(negedge clk);
            rdy = (ch == 0) ? m_rready : (ch == 1) ? m_wvalid : m_bready;
        end
        if (!rdy) begin
            $display("Memory model: master stalled on channel %0d at %0t", ch, $time);
            stall_cnt++;
        end
    endtask

    // ====================
    // Address phase
    // ====================

    task automatic take_address(input logic is_rd);
        rng = xorshift(rng);
        repeat (1 + rng % 3) cycle;
        cur_addr = m_axaddr;
        cur_len  = m_axlen;
        cur_id   = m_axid;
        // Same ID, address and direction as last time means a reissue
        first_try = !(prev_ok && prev_addr == cur_addr && prev_id == cur_id
                      && prev_rd == is_rd);
        prev_ok   = 1'b1;
        prev_addr = cur_addr;
        prev_id   = cur_id;
        prev_rd   = is_rd;
        log_addr[log_cnt] = cur_addr;
        log_len[log_cnt]  = cur_len;
        log_id[log_cnt]   = cur_id;
        log_rd[log_cnt]   = is_rd;
        log_cnt++;
        if (is_rd)
            s_arready = 1'b1;
        else
            s_awready = 1'b1;
        cycle;
        s_arready = 1'b0;
        s_awready = 1'b0;
    endtask

    // ====================
    // Read channel
    // ====================

    task automatic send_rbeat(input data_t d, input id_t id, input resp_t resp,
                              input logic last);
        rng = xorshift(rng);
        repeat (rng % 2) cycle;
        s_rvalid = 1'b1;
        s_rdata  = d;
        s_rid    = id;
        s_rresp  = resp;
        s_rlast  = last;
        wait_ready(0);
        cycle;
        s_rvalid = 1'b0;
        s_rlast  = 1'b0;
    endtask

    task automatic serve_read;
        int i;
        int err_beat;
        take_address(1'b1);
        rng = xorshift(rng);
        err_beat = (inject_err && first_try) ? int'(rng % (cur_len + 1)) : -1;
        for (i = 0; i <= cur_len; i++) begin
            rng = xorshift(rng);
            // Foreign-ID beat slipped in ahead of the real one
            if (stray_en && rng[4])
                send_rbeat(rng, cur_id ^ 4'h9, RESP_OKAY, 1'b0);
            send_rbeat(read_word(cur_addr + 4 * i), cur_id,
                       (i == err_beat) ? RESP_SLVERR : RESP_OKAY, i == cur_len);
        end
    endtask

    // ====================
    // Write channels
    // ====================

    task automatic serve_write;
        int i;
        int k;
        addr_t a;
        logic [9:0] idx;
        take_address(1'b0);
        for (i = 0; i <= cur_len; i++) begin
            rng = xorshift(rng);
            repeat (rng % 2) cycle;
            s_wready = 1'b1;
            wait_ready(1);
            // Beat is taken on the coming edge
            a = cur_addr + 4 * i;
            for (k = 0; k < 4; k++) begin
                idx = a[9:0] + k;
                if (m_wstrb[k])
                    mem[idx] = m_wdata[8*k +: 8];
            end
            if (m_wlast != (i == cur_len))
                wlast_err++;
            cycle;
            s_wready = 1'b0;
        end
        rng = xorshift(rng);
        repeat (rng % 2) cycle;
        s_bvalid = 1'b1;
        s_bid    = cur_id;
        s_bresp  = (inject_err && first_try) ? RESP_SLVERR : RESP_OKAY;
        wait_ready(2);
        cycle;
        s_bvalid = 1'b0;
    endtask

    initial begin
        s_arready = 1'b0;
        s_awready = 1'b0;
        s_wready  = 1'b0;
        s_rvalid  = 1'b0;
        s_rdata   = '0;
        s_rid     = '0;
        s_rresp   = RESP_OKAY;
        s_rlast   = 1'b0;
        s_bvalid  = 1'b0;
        s_bid     = '0;
        s_bresp   = RESP_OKAY;
        rng       = 32'h44c1;
        prev_ok   = 1'b0;
        log_cnt   = 0;
        wlast_err = 0;
        stall_cnt = 0;
        // Requests are looked for at the falling edge
        forever begin
            @(negedge clk);
            if (m_arvalid === 1'b1)
                serve_read;
            else if (m_awvalid === 1'b1)
                serve_write;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_vlsu_axi_master.sv
// Testbench for the VLSU AXI4 burst master
// Store/load pairs against a shadow memory, ID, retry and busy checks

`timescale 1ns/1ps
`default_nettype none

module tb_vlsu_axi_master
    import vlsu_axi_pkg::*;
();

    localparam int PAIRS = 20;

    logic        clk;
    logic        reset;

    // Unit side
    logic        ld_req;
    logic        st_req;
    addr_t       base_addr;
    len_t        burst_len;
    burst_data_t vlsu_wdata;
    burst_strb_t write_strobe;
    burst_data_t burst_rdata_array;
    logic        burst_valid_data;
    logic        burst_wr_valid;
    logic        busy;

    // AXI side
    addr_t       m_axaddr;
    len_t        m_axlen;
    id_t         m_axid;
    logic        m_arvalid;
    logic        m_awvalid;
    logic        s_arready;
    logic        s_awready;
    data_t       m_wdata;
    strb_t       m_wstrb;
    logic        m_wlast;
    logic        m_wvalid;
    logic        s_wready;
    logic        s_rvalid;
    data_t       s_rdata;
    id_t         s_rid;
    resp_t       s_rresp;
    logic        s_rlast;
    logic        m_rready;
    logic        s_bvalid;
    id_t         s_bid;
    resp_t       s_bresp;
    logic        m_bready;

    // Model controls
    logic        inject_err;
    logic        stray_en;

    // Shadow memory and expectations for the compare process
    logic [7:0]  shadow [0:1023];
    burst_data_t exp_rdata;
    addr_t       exp_addr;
    len_t        exp_len;
    id_t         exp_id;

    logic [31:0] rng;
    int          err_cnt;
    int          check_cnt;
    int          loads_checked;
    int          stores_checked;
    logic        rd_flag_q;
    logic        wr_flag_q;

    vlsu_axi_master dut_i (.*);

    axi_mem_model mem_i (.*);

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Initial memory contents built from every address bit
    function automatic logic [7:0] fill_byte(input logic [9:0] a);
        return a[7:0] ^ {4{a[9:8]}};
    endfunction

    // Expected load result from the shadow memory
    // Byte b of the burst comes from addr+b
    function automatic burst_data_t expected_burst(input addr_t addr, input len_t len);
        burst_data_t r;
        logic [9:0] idx;
        int b;
        r = '0;
        for (b = 0; b < 4 * (len + 1); b++) begin
            idx = addr[9:0] + b;
            r[8*b +: 8] = shadow[idx];
        end
        return r;
    endfunction

    // Store lands in the shadow only where its strobe is set
    task automatic merge_store(input addr_t addr, input len_t len,
                               input burst_data_t data, input burst_strb_t strb);
        logic [9:0] idx;
        int b;
        for (b = 0; b < 4 * (len + 1); b++) begin
            idx = addr[9:0] + b;
            if (strb[b])
                shadow[idx] = data[8*b +: 8];
        end
    endtask

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string msg);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)",
                     $time, msg, actual, expected);
        end
    endtask

    // Polls the done flag at the falling edge
    task automatic wait_done(input logic is_load);
        int n;
        n = 0;
        @(negedge clk);
        while (!(is_load ? burst_valid_data : burst_wr_valid) && n < 2000) begin
            n++;
            @(negedge clk);
        end
        if (!(is_load ? burst_valid_data : burst_wr_valid)) begin
            $display("Timeout: %s never rose after the request at %0t",
                     is_load ? "burst_valid_data" : "burst_wr_valid", $time);
            $display("Test FAILED");
            $finish;
        end
    endtask

    // ====================
    // One request
    // ====================

    task automatic run_burst(input logic is_load, input addr_t addr, input len_t len,
                             input burst_data_t data, input burst_strb_t strb,
                             input logic inject, input logic stray, input logic extra);
        int first;
        int e;
        first = mem_i.log_cnt;
        @(posedge clk);
        #1;
        // Expected results for this request
        if (is_load)
            exp_rdata = expected_burst(addr, len);
        else
            merge_store(addr, len, data, strb);
        exp_addr     = addr;
        exp_len      = len;
        inject_err   = inject;
        stray_en     = stray;
        ld_req       = is_load;
        st_req       = !is_load;
        base_addr    = addr;
        burst_len    = len;
        vlsu_wdata   = data;
        write_strobe = strb;
        @(posedge clk);
        #1;
        ld_req = 1'b0;
        st_req = 1'b0;
        check_value(busy, 1'b1, "busy after request accept");
        // Second request while busy is to be dropped
        if (extra) begin
            ld_req    = 1'b1;
            st_req    = 1'b1;
            base_addr = addr ^ 32'h200;
            burst_len = '0;
            @(posedge clk);
            #1;
            ld_req = 1'b0;
            st_req = 1'b0;
        end
        wait_done(is_load);
        // Error injection costs exactly one reissue
        check_value(mem_i.log_cnt - first, inject ? 2 : 1, "address handshakes per request");
        for (e = first; e < mem_i.log_cnt; e++) begin
            check_value(mem_i.log_addr[e], addr, "logged burst address");
            check_value(mem_i.log_len[e], len, "logged burst length");
            check_value(mem_i.log_id[e], exp_id, "logged burst ID");
            check_value(mem_i.log_rd[e], is_load, "logged burst direction");
        end
        exp_id = exp_id + 1'b1;
    endtask

    task automatic store_then_load(input int iter);
        addr_t addr;
        len_t len;
        burst_data_t data;
        burst_strb_t strb;
        int w;
        rng  = xorshift(rng);
        addr = {22'h0, rng[9:2], 2'b00};
        len  = rng[13:12];
        for (w = 0; w < 4; w++) begin
            rng = xorshift(rng);
            data[32*w +: 32] = rng;
        end
        rng  = xorshift(rng);
        strb = rng[15:0];
        run_burst(1'b0, addr, len, data, strb, iter % 3 == 1, 1'b0, iter % 4 == 3);
        run_burst(1'b1, addr, len, '0, '0, iter % 3 == 2, iter % 2 == 1, iter % 4 == 1);
    endtask

    // ====================
    // Clock and compare
    // ====================

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Outputs checked on the rising of each done flag
    always @(negedge clk) begin : compare_outputs
        int i;
        logic [9:0] idx;
        if (burst_valid_data && !rd_flag_q) begin
            for (i = 0; i <= exp_len; i++)
                check_value(burst_rdata_array[32*i +: 32], exp_rdata[32*i +: 32],
                            "load beat data");
            loads_checked++;
        end
        if (burst_wr_valid && !wr_flag_q) begin
            for (i = 0; i < 4 * (exp_len + 1); i++) begin
                idx = exp_addr[9:0] + i;
                check_value(mem_i.mem[idx], shadow[idx], "memory byte after store");
            end
            stores_checked++;
        end
        rd_flag_q = burst_valid_data;
        wr_flag_q = burst_wr_valid;
    end

    // ====================
    // Stimulus
    // ====================

    initial begin : stimulus
        int i;
        reset          = 1'b0;
        ld_req         = 1'b0;
        st_req         = 1'b0;
        base_addr      = '0;
        burst_len      = '0;
        vlsu_wdata     = '0;
        write_strobe   = '0;
        inject_err     = 1'b0;
        stray_en       = 1'b0;
        rng            = 32'h44c1;
        exp_id         = '0;
        exp_rdata      = '0;
        exp_addr       = '0;
        exp_len        = '0;
        err_cnt        = 0;
        check_cnt      = 0;
        loads_checked  = 0;
        stores_checked = 0;
        rd_flag_q      = 1'b0;
        wr_flag_q      = 1'b0;
        for (i = 0; i < 1024; i++) begin
            shadow[i]    = fill_byte(i);
            mem_i.mem[i] = fill_byte(i);
        end

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b1;

        // Idle outputs straight after reset
        check_value(m_arvalid, 1'b0, "arvalid after reset");
        check_value(m_awvalid, 1'b0, "awvalid after reset");
        check_value(m_wvalid, 1'b0, "wvalid after reset");
        check_value(m_rready, 1'b0, "rready after reset");
        check_value(m_bready, 1'b0, "bready after reset");
        check_value(burst_valid_data, 1'b0, "burst_valid_data after reset");
        check_value(burst_wr_valid, 1'b0, "burst_wr_valid after reset");
        check_value(busy, 1'b0, "busy after reset");
        check_value(m_axid, 4'h0, "ID after reset");

        // Forty requests wrap the ID twice
        for (i = 0; i < PAIRS; i++)
            store_then_load(i);

        @(posedge clk);
        #1;
        check_value(loads_checked, PAIRS, "completed loads");
        check_value(stores_checked, PAIRS, "completed stores");
        check_value(mem_i.wlast_err, 0, "wlast placement in the model");
        check_value(mem_i.stall_cnt, 0, "stalls seen by the model");

        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/vlsu_axi_pkg.sv
verilog/burst_config_regs.sv
verilog/axi_channel_ctrl.sv
verilog/burst_completion.sv
verilog/vlsu_axi_master.sv
tests/axi_mem_model.sv
tests/tb_vlsu_axi_master.sv
